/* ex_unit.f */
+incdir+include
logic/ex_op_pkg.sv
logic/ex_data_pkg.sv
logic/ex_issue.sv
logic/ex_alu.sv
logic/ex_mul.sv
logic/ex_writeback.sv
logic/ex_unit.sv
verif/ex_unit_tb.sv

/* Bender.yml */
package:
  name: ex_unit

export_include_dirs:
  - include

sources:
  - logic/ex_op_pkg.sv
  - logic/ex_data_pkg.sv
  - logic/ex_issue.sv
  - logic/ex_alu.sv
  - logic/ex_mul.sv
  - logic/ex_writeback.sv
  - logic/ex_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/ex_unit_tb.sv

/* include/ex_ref_model.svh */
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// word forms leave the upper word zero for the extension mode
function automatic logic [XLEN-1:0] alu_value(ex_req_t r);
    logic [5:0]  sh;
    logic [31:0] w;
    sh = r.src2[5:0];
    case (r.op)
        PASS: return r.src2;
        ADD:  return r.word ? {32'b0, r.src1[31:0] + r.src2[31:0]} : r.src1 + r.src2;
        SUB:  return r.word ? {32'b0, r.src1[31:0] - r.src2[31:0]} : r.src1 - r.src2;
        SLL: begin
            w = r.src1[31:0] << sh[4:0];
            return r.word ? {32'b0, w} : r.src1 << sh;
        end
        SRL: begin
            w = r.src1[31:0] >> sh[4:0];
            return r.word ? {32'b0, w} : r.src1 >> sh;
        end
        SRA: begin
            w = $signed(r.src1[31:0]) >>> sh[4:0];
            if (r.word) begin
                return {32'b0, w};
            end
            return $signed(r.src1) >>> sh;
        end
        SLT:  return {{(XLEN-1){1'b0}}, $signed(r.src1) < $signed(r.src2)};
        SLTU: return {{(XLEN-1){1'b0}}, r.src1 < r.src2};
        XOR:  return r.src1 ^ r.src2;
        OR:   return r.src1 | r.src2;
        AND:  return r.src1 & r.src2;
        default: return '0;
    endcase
endfunction

// full product with one extra sign bit per operand
function automatic logic [XLEN-1:0] product_half(ex_req_t r);
    logic signed [XLEN:0]     a;
    logic signed [XLEN:0]     b;
    logic signed [2*XLEN+1:0] p;
    a = {(r.op == MULH || r.op == MULHSU) & r.src1[XLEN-1], r.src1};
    b = {(r.op == MULH) & r.src2[XLEN-1], r.src2};
    p = a * b;
    return (r.op == MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
endfunction

function automatic logic [XLEN-1:0] extend_value(ext_mode_e ext, logic [XLEN-1:0] v);
    case (ext)
        SEXT_W:  return {{(XLEN-32){v[31]}}, v[31:0]};
        ZEXT_W:  return {{(XLEN-32){1'b0}}, v[31:0]};
        SEXT_H:  return {{(XLEN-16){v[15]}}, v[15:0]};
        SEXT_B:  return {{(XLEN-8){v[7]}}, v[7:0]};
        default: return v;
    endcase
endfunction

function automatic logic branch_taken(ex_req_t r);
    if (r.op != BR) begin
        return 1'b0;
    end
    case (r.cmp)
        EQ:  return r.src1 == r.src2;
        NE:  return r.src1 != r.src2;
        LT:  return $signed(r.src1) < $signed(r.src2);
        GE:  return $signed(r.src1) >= $signed(r.src2);
        LTU: return r.src1 < r.src2;
        GEU: return r.src1 >= r.src2;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [XLEN-1:0] expected_result(ex_req_t r);
    logic is_mul;
    is_mul = r.op inside {MUL, MULH, MULHSU, MULHU};
    return extend_value(r.ext, is_mul ? product_half(r) : alu_value(r));
endfunction

`endif

/* verif/ex_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_unit_tb
    import ex_op_pkg::*;
    import ex_data_pkg::*;
();

    `include "ex_ref_model.svh"

    localparam int TIMEOUT = 200; // cycles per wait loop

    logic            clk;
    logic            rst_n;
    logic            issue;
    ex_req_t         req;
    logic            busy;
    logic            result_valid;
    ex_rsp_t         rsp;
    logic            pending;     // a result is still owed
    logic            mul_pending;
    logic [XLEN-1:0] exp_res;
    logic            exp_cond;
    integer          seed;

    ex_unit #(.MUL_BITS_PER_CYCLE(1)) i_ex_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .req          (req),
        .busy         (busy),
        .result_valid (result_valid),
        .rsp          (rsp)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        stop_run($sformatf("** Error at %0t: %s expected %h, got %h",
                           $time, name, expected, actual));
    endtask

    function automatic logic multiplies(alu_op_e op);
        return op inside {MUL, MULH, MULHSU, MULHU};
    endfunction

    function logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic ex_req_t make_req(alu_op_e op, cmp_op_e cmp, logic word,
                                         ext_mode_e ext, logic [XLEN-1:0] src1,
                                         logic [XLEN-1:0] src2);
        return '{op: op, cmp: cmp, word: word, ext: ext, src1: src1, src2: src2};
    endfunction

    // one-cycle strobe with its expected response
    task automatic send(input ex_req_t r);
        @(negedge clk);
        req         = r;
        issue       = 1'b1;
        exp_res     = expected_result(r);
        exp_cond    = branch_taken(r);
        pending     = 1'b1;
        mul_pending = multiplies(r.op);
        @(negedge clk);
        issue = 1'b0;
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (!result_valid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_run("result never arrived");
        end
        @(negedge clk); // let the checks see the pulse first
        pending     = 1'b0;
        mul_pending = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) stop_run("busy never fell");
        end
    endtask

    task automatic run(input ex_req_t r);
        send(r);
        wait_result();
    endtask

    a_owed: assert property (@(posedge clk) disable iff (!rst_n) result_valid |-> pending)
        else stop_run("result_valid pulsed with no request outstanding");
    a_res: assert property (@(posedge clk) disable iff (!rst_n)
            result_valid |-> rsp.res == exp_res)
        else report_mismatch("rsp.res", exp_res, $sampled(rsp.res));
    a_cond: assert property (@(posedge clk) disable iff (!rst_n)
            result_valid |-> rsp.cond == exp_cond)
        else report_mismatch("rsp.cond", exp_cond, $sampled(rsp.cond));
    a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            result_valid |=> !result_valid)
        else stop_run("result_valid held for more than one cycle");
    a_alu_lat: assert property (@(posedge clk) disable iff (!rst_n)
            (issue && !busy && !multiplies(req.op)) |=> !result_valid ##1 result_valid)
        else stop_run("non-multiply result not one cycle after the issue cycle");
    a_mul_busy: assert property (@(posedge clk) disable iff (!rst_n)
            (mul_pending && $past(mul_pending) && !result_valid) |-> busy)
        else report_mismatch("busy", 1, $sampled(busy));
    a_idle: assert property (@(posedge clk) disable iff (!rst_n) !mul_pending |-> !busy)
        else report_mismatch("busy", 0, $sampled(busy));

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue       = 1'b0;
        req         = '0;
        pending     = 1'b0;
        mul_pending = 1'b0;
        exp_res     = '0;
        exp_cond    = 1'b0;
        seed        = 11;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (busy == 1'b0) else report_mismatch("busy", 0, busy);
        assert (result_valid == 1'b0) else report_mismatch("result_valid", 0, result_valid);
        assert (rsp.res == '0) else report_mismatch("rsp.res", 0, rsp.res);
        assert (rsp.cond == 1'b0) else report_mismatch("rsp.cond", 0, rsp.cond);

        // PASS through AND in both widths
        for (int w = 0; w < 2; w++) begin
            for (int op = 0; op <= 10; op++) begin
                run(make_req(alu_op_e'(op), EQ, w[0], NONE, rand64(), rand64()));
            end
        end
        run(make_req(ADD, EQ, 1'b1, SEXT_W, 64'h0000_0000_7fff_ffff, 64'h1)); // wraps
        run(make_req(SUB, EQ, 1'b1, SEXT_W, 64'h0, 64'h1));
        run(make_req(SRA, EQ, 1'b1, SEXT_W, 64'hdead_beef_8000_0000, 64'h3f)); // bit 5 unused
        run(make_req(SRL, EQ, 1'b1, SEXT_W, 64'hffff_ffff_8000_0000, 64'h1f));
        run(make_req(SRA, EQ, 1'b0, NONE, 64'h8000_0000_0000_0000, 64'h3f));

        // signed and unsigned order disagree here
        for (int c = 0; c <= 5; c++) begin
            a = rand64();
            a[XLEN-1] = 1'b1;
            b = rand64();
            b[XLEN-1] = 1'b0;
            run(make_req(BR, cmp_op_e'(c), 1'b0, NONE, a, b));
            run(make_req(BR, cmp_op_e'(c), 1'b0, NONE, b, a));
            run(make_req(BR, cmp_op_e'(c), 1'b0, NONE, a, a));
        end

        for (int op = 11; op <= 14; op++) begin
            a = rand64();
            a[XLEN-1] = 1'b1;
            b = rand64();
            b[XLEN-1] = 1'b1;
            run(make_req(alu_op_e'(op), EQ, 1'b0, NONE, rand64(), rand64()));
            run(make_req(alu_op_e'(op), EQ, 1'b0, NONE, a, rand64()));
            run(make_req(alu_op_e'(op), EQ, 1'b0, NONE, rand64(), b));
            run(make_req(alu_op_e'(op), EQ, 1'b0, NONE, a, b));
            run(make_req(alu_op_e'(op), EQ, 1'b0, NONE, {1'b1, 63'b0}, {1'b1, 63'b0}));
        end

        // strobe during a multiply must be dropped
        send(make_req(MULH, EQ, 1'b0, SEXT_W, rand64(), rand64()));
        repeat (3) @(negedge clk);
        assert (busy) else stop_run("busy not high during the multiply");
        req   = make_req(ADD, EQ, 1'b0, NONE, rand64(), rand64());
        issue = 1'b1;
        @(negedge clk);
        issue = 1'b0;
        wait_result();
        repeat (5) @(negedge clk); // a late pulse trips a_owed
        wait_idle();
        run(make_req(XOR, EQ, 1'b0, NONE, rand64(), rand64()));

        for (int e = 0; e <= 4; e++) begin
            run(make_req(PASS, EQ, 1'b0, ext_mode_e'(e), rand64(), 64'h0123_4567_89ab_cdef));
            run(make_req(PASS, EQ, 1'b0, ext_mode_e'(e), rand64(), 64'hfedc_ba98_7654_3210));
        end

        repeat (3) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/ex_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_unit
    import ex_data_pkg::*;
#(
    parameter int MUL_BITS_PER_CYCLE = 1
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    issue,
    input  ex_req_t req,
    output logic    busy,
    output logic    result_valid,
    output ex_rsp_t rsp
);

    logic            alu_go;
    ex_req_t         alu_req;
    ex_rsp_t         alu_rsp;
    logic            mul_start;
    mul_req_t        mul_req;
    logic            mul_done;
    logic [XLEN-1:0] mul_res;

    ex_issue i_ex_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .req       (req),
        .busy      (busy),
        .alu_go    (alu_go),
        .alu_req   (alu_req),
        .mul_start (mul_start),
        .mul_req   (mul_req),
        .mul_done  (mul_done)
    );

    ex_alu i_ex_alu (
        .alu_req (alu_req),
        .alu_rsp (alu_rsp)
    );

    ex_mul #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) i_ex_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .mul_req   (mul_req),
        .mul_done  (mul_done),
        .mul_res   (mul_res)
    );

    // ext of the held request also applies to a multiply
    ex_writeback i_ex_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu_go       (alu_go),
        .alu_rsp      (alu_rsp),
        .mul_done     (mul_done),
        .mul_res      (mul_res),
        .ext          (alu_req.ext),
        .result_valid (result_valid),
        .rsp          (rsp)
    );

endmodule

`default_nettype wire

/* logic/ex_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_writeback
    import ex_op_pkg::*;
    import ex_data_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            alu_go,
    input  ex_rsp_t         alu_rsp,
    input  logic            mul_done,
    input  logic [XLEN-1:0] mul_res,
    input  ext_mode_e       ext,
    output logic            result_valid,
    output ex_rsp_t         rsp
);

    logic            sel_valid;
    logic [XLEN-1:0] sel_res;
    logic            sel_cond;
    logic [XLEN-1:0] ext_res;

    // alu_go and mul_done never overlap, busy blocks issue meanwhile
    assign sel_valid = alu_go | mul_done;
    assign sel_res   = mul_done ? mul_res : alu_rsp.res;
    assign sel_cond  = mul_done ? 1'b0 : alu_rsp.cond;

    always_comb begin
        case (ext)
            SEXT_W:  ext_res = {{(XLEN-32){sel_res[31]}}, sel_res[31:0]};
            ZEXT_W:  ext_res = {{(XLEN-32){1'b0}}, sel_res[31:0]};
            SEXT_H:  ext_res = {{(XLEN-16){sel_res[15]}}, sel_res[15:0]};
            SEXT_B:  ext_res = {{(XLEN-8){sel_res[7]}}, sel_res[7:0]};
            default: ext_res = sel_res;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            rsp          <= '0;
        end else begin
            result_valid <= sel_valid; // single pulse, not held
            if (sel_valid) begin
                rsp <= '{res: ext_res, cond: sel_cond};
            end
        end
    end

endmodule

`default_nettype wire

/* logic/ex_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mul
    import ex_data_pkg::*;
#(
    parameter int MUL_BITS_PER_CYCLE = 1
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mul_start,
    input  mul_req_t        mul_req,
    output logic            mul_done,
    output logic [XLEN-1:0] mul_res
);

    localparam int STEPS = XLEN / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS) + 1;

    logic              running;
    logic [CNT_W-1:0]  cnt;
    logic              last_step;
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [2*XLEN-1:0] acc;
    logic [2*XLEN-1:0] mcand;  // shifts left each step
    logic [XLEN-1:0]   mplier; // shifts right each step
    logic [2*XLEN-1:0] acc_next;
    logic [2*XLEN-1:0] prod;
    logic              neg;
    logic              high;

    // magnitudes; -2^63 maps onto itself, which is right unsigned
    assign a_neg = mul_req.src1_signed & mul_req.src1[XLEN-1];
    assign b_neg = mul_req.src2_signed & mul_req.src2[XLEN-1];
    assign a_mag = a_neg ? -mul_req.src1 : mul_req.src1;
    assign b_mag = b_neg ? -mul_req.src2 : mul_req.src2;

    // partial product of the low multiplier bits
    assign acc_next = acc + mcand * mplier[MUL_BITS_PER_CYCLE-1:0];
    assign prod     = neg ? -acc_next : acc_next;

    assign last_step = running && (cnt == CNT_W'(STEPS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= last_step;
            if (mul_start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (last_step) begin
                running <= 1'b0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            acc    <= '0;
            mcand  <= {{XLEN{1'b0}}, a_mag};
            mplier <= b_mag;
            neg    <= a_neg ^ b_neg;
            high   <= mul_req.high;
        end else if (running) begin
            acc    <= acc_next;
            mcand  <= mcand << MUL_BITS_PER_CYCLE;
            mplier <= mplier >> MUL_BITS_PER_CYCLE;
        end
        if (last_step) begin
            mul_res <= high ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0]; // sign restored
        end
    end

endmodule

`default_nettype wire

/* logic/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import ex_op_pkg::*;
    import ex_data_pkg::*;
(
    input  ex_req_t alu_req,
    output ex_rsp_t alu_rsp
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [5:0]      shamt;
    logic [31:0]     add_w;
    logic [31:0]     sub_w;
    logic [31:0]     sll_w;
    logic [31:0]     srl_w;
    logic [31:0]     sra_w;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] alu_res;
    logic            cmp_hit;
    logic            br_cond;

    assign a = alu_req.src1;
    assign b = alu_req.src2;

    // word shifts only look at 5 bits
    assign shamt = b[5:0];

    // 32-bit forms; the upper word is left to the extension mode
    assign add_w = a[31:0] + b[31:0];
    assign sub_w = a[31:0] - b[31:0];
    assign sll_w = a[31:0] << shamt[4:0];
    assign srl_w = a[31:0] >> shamt[4:0];
    assign sra_w = $signed(a[31:0]) >>> shamt[4:0];

    // shared by slt and the branch compare
    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (alu_req.op)
            PASS: alu_res = b;
            ADD: begin
                if (alu_req.word) begin
                    alu_res = {32'b0, add_w};
                end else begin
                    alu_res = a + b;
                end
            end
            SUB: begin
                if (alu_req.word) begin
                    alu_res = {32'b0, sub_w};
                end else begin
                    alu_res = a - b;
                end
            end
            SLL: begin
                if (alu_req.word) begin
                    alu_res = {32'b0, sll_w};
                end else begin
                    alu_res = a << shamt;
                end
            end
            SRL: begin
                if (alu_req.word) begin
                    alu_res = {32'b0, srl_w};
                end else begin
                    alu_res = a >> shamt;
                end
            end
            SRA: begin
                if (alu_req.word) begin
                    alu_res = {32'b0, sra_w};
                end else begin
                    alu_res = $signed(a) >>> shamt;
                end
            end
            SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
            SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_u};
            XOR:  alu_res = a ^ b;
            OR:   alu_res = a | b;
            AND:  alu_res = a & b;
            default: alu_res = '0; // multiply ops and BR
        endcase
    end

    always_comb begin
        case (alu_req.cmp)
            EQ:  cmp_hit = eq;
            NE:  cmp_hit = !eq;
            LT:  cmp_hit = lt_s;
            GE:  cmp_hit = !lt_s;
            LTU: cmp_hit = lt_u;
            GEU: cmp_hit = !lt_u;
            default: cmp_hit = 1'b0;
        endcase
    end

    assign br_cond = (alu_req.op == BR) && cmp_hit; // zero for all other ops

    assign alu_rsp = '{res: alu_res, cond: br_cond};

endmodule

`default_nettype wire

/* logic/ex_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_issue
    import ex_op_pkg::*;
    import ex_data_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     issue,
    input  ex_req_t  req,
    output logic     busy,
    output logic     alu_go,
    output ex_req_t  alu_req,
    output logic     mul_start,
    output mul_req_t mul_req,
    input  logic     mul_done
);

    logic accept;
    logic is_mul;

    assign accept = issue && !busy; // strobes while busy are dropped
    assign is_mul = req.op inside {MUL, MULH, MULHSU, MULHU};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            alu_go    <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            alu_go    <= accept && !is_mul;
            mul_start <= accept && is_mul;
            if (accept && is_mul) begin
                busy <= 1'b1;
            end else if (mul_done) begin
                busy <= 1'b0; // drops with result_valid
            end
        end
    end

    // request held until the next accepted issue
    // ext stays valid for the multiplier result too
    always_ff @(posedge clk) begin
        if (accept) begin
            alu_req             <= req;
            mul_req.src1        <= req.src1;
            mul_req.src2        <= req.src2;
            mul_req.src1_signed <= (req.op == MULH) || (req.op == MULHSU);
            mul_req.src2_signed <= (req.op == MULH);
            mul_req.high        <= (req.op != MUL);
        end
    end

endmodule

`default_nettype wire

/* logic/ex_data_pkg.sv */
`default_nettype none

package ex_data_pkg;

    import ex_op_pkg::*;

    localparam int XLEN = 64;

    // one issued operation
    typedef struct packed {
        alu_op_e          op;
        cmp_op_e          cmp;
        logic             word;  // 32-bit form of add, sub and shifts
        ext_mode_e        ext;
        logic [XLEN-1:0]  src1;
        logic [XLEN-1:0]  src2;
    } ex_req_t;

    // operands and mode for the multiplier
    typedef struct packed {
        logic [XLEN-1:0]  src1;
        logic [XLEN-1:0]  src2;
        logic             src1_signed;
        logic             src2_signed;
        logic             high;  // upper half of the product
    } mul_req_t;

    typedef struct packed {
        logic [XLEN-1:0]  res;
        logic             cond;  // branch taken, BR only
    } ex_rsp_t;

endpackage

`default_nettype wire

/* logic/ex_op_pkg.sv */
`default_nettype none

package ex_op_pkg;

    // integer execute operations
    typedef enum logic [4:0] {
        PASS   = 5'd0,  // src2 straight through, load data and links
        ADD    = 5'd1,
        SUB    = 5'd2,
        SLL    = 5'd3,
        SLT    = 5'd4,
        SLTU   = 5'd5,
        XOR    = 5'd6,
        SRL    = 5'd7,
        SRA    = 5'd8,
        OR     = 5'd9,
        AND    = 5'd10,
        MUL    = 5'd11, // low half
        MULH   = 5'd12, // signed x signed, high half
        MULHSU = 5'd13, // signed x unsigned, high half
        MULHU  = 5'd14, // unsigned x unsigned, high half
        BR     = 5'd15  // branch compare, result in cond
    } alu_op_e;

    // branch conditions
    typedef enum logic [2:0] {
        EQ  = 3'd0,
        NE  = 3'd1,
        LT  = 3'd2,
        GE  = 3'd3,
        LTU = 3'd4,
        GEU = 3'd5
    } cmp_op_e;

    // extension of the final value to 64 bits
    typedef enum logic [2:0] {
        NONE   = 3'd0,
        SEXT_W = 3'd1, // from bit 31
        ZEXT_W = 3'd2, // upper word cleared
        SEXT_H = 3'd3, // from bit 15
        SEXT_B = 3'd4  // from bit 7
    } ext_mode_e;

endpackage

`default_nettype wire
